// ==== flist.f ====
+incdir+.
rv32i_pkg.sv
regfile.sv
control_rom.sv
branch_unit.sv
decode_stage.sv
decode_checker.sv
tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: rv32i_decode_stage

sources:
  - include_dirs:
      - .
    files:
      - rv32i_pkg.sv
      - regfile.sv
      - control_rom.sv
      - branch_unit.sv
      - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - decode_checker.sv
      - tb_decode_stage.sv

// ==== tb_decode_stage.sv ====
`include "rv32i_cfg.svh"

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_cycles = 2000;

    logic                  clk;
    logic                  rst_i;
    logic [`XLEN-1:0]      instr_i;
    logic [`XLEN-1:0]      pc_i;
    rv32i_pkg::wb_port_t   wb_i;
    rv32i_pkg::fwd_bus_t   fwd_i;
    rv32i_pkg::fwd_sel_e   fwd_rs1_sel_i;
    rv32i_pkg::fwd_sel_e   fwd_rs2_sel_i;
    logic                  bubble_i;
    logic                  br_pred_i;
    rv32i_pkg::id_ex_t     id_ex_o;
    logic [`XLEN-1:0]      target_o;
    rv32i_pkg::pc_sel_e    pc_sel_o;
    logic                  flush_o;

    int     error_count;
    int     check_count;
    int     waited;
    logic   timed_out;
    integer seed = 32'he93a;

    rv32i_pkg::opcode_e legal_ops [9] = '{rv32i_pkg::op_lui, rv32i_pkg::op_auipc,
        rv32i_pkg::op_jal, rv32i_pkg::op_jalr, rv32i_pkg::op_br, rv32i_pkg::op_load,
        rv32i_pkg::op_store, rv32i_pkg::op_imm, rv32i_pkg::op_reg};

    decode_stage u_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_i          (wb_i),
        .fwd_i         (fwd_i),
        .fwd_rs1_sel_i (fwd_rs1_sel_i),
        .fwd_rs2_sel_i (fwd_rs2_sel_i),
        .bubble_i      (bubble_i),
        .br_pred_i     (br_pred_i),
        .id_ex_o       (id_ex_o),
        .target_o      (target_o),
        .pc_sel_o      (pc_sel_o),
        .flush_o       (flush_o)
    );

    decode_checker u_checker (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_i          (wb_i),
        .fwd_i         (fwd_i),
        .fwd_rs1_sel_i (fwd_rs1_sel_i),
        .fwd_rs2_sel_i (fwd_rs2_sel_i),
        .bubble_i      (bubble_i),
        .br_pred_i     (br_pred_i),
        .id_ex_i       (id_ex_o),
        .target_i      (target_o),
        .pc_sel_i      (pc_sel_o),
        .flush_i       (flush_o),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    always #10 clk = ~clk;

    // small values half the time so equal and sign-crossing compares show up
    function automatic logic [`XLEN-1:0] random_word();
        logic [`XLEN-1:0] r;
        r = $random(seed);
        if (r[0]) r = {{30{r[5]}}, r[2:1]};
        return r;
    endfunction

    task automatic drive_random_inputs();
        logic [`XLEN-1:0] r;
        logic [`XLEN-1:0] fields;
        logic [`XLEN-1:0] sel_a;
        logic [`XLEN-1:0] sel_b;
        logic [6:0]       op;
        r      = $random(seed);
        fields = $random(seed);
        sel_a  = $unsigned($random(seed)) % 6;
        sel_b  = $unsigned($random(seed)) % 6;
        op     = legal_ops[r[7:0] % 9];
        if (r[11:8] == 4'h0) op = r[18:12];   // now and then an unknown opcode
        instr_i         <= {fields[31:7], op};
        pc_i            <= $random(seed) & 32'hffff_fffc;
        wb_i.load       <= r[19];
        wb_i.rd         <= r[24:20];
        wb_i.data       <= random_word();
        fwd_i.ex_alu    <= random_word();
        fwd_i.mem_alu   <= random_word();
        fwd_i.mem_ld    <= random_word();
        fwd_i.wb_alu    <= random_word();
        fwd_i.wb_ld     <= random_word();
        fwd_rs1_sel_i   <= rv32i_pkg::fwd_sel_e'(sel_a[2:0]);
        fwd_rs2_sel_i   <= rv32i_pkg::fwd_sel_e'(sel_b[2:0]);
        bubble_i        <= (r[30:28] == 3'b000);   // about one in eight
        br_pred_i       <= r[31];
    endtask

    initial begin
        clk           = 1'b0;
        rst_i         = 1'b1;
        instr_i       = '0;
        pc_i          = '0;
        wb_i          = '0;
        fwd_i         = '0;
        fwd_rs1_sel_i = rv32i_pkg::id;
        fwd_rs2_sel_i = rv32i_pkg::id;
        bubble_i      = 1'b0;
        br_pred_i     = 1'b0;
        timed_out     = 1'b0;
        waited        = 0;

        repeat (3) @(posedge clk);
        rst_i <= 1'b0;

        for (int i = 0; i < num_cycles; i++) begin
            @(posedge clk);
            drive_random_inputs();
        end

        // one check for the post-reset idle cycle plus one per driven cycle
        while (check_count < num_cycles + 1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        timed_out = (check_count < num_cycles + 1);
        if (timed_out) begin
            $display("Timeout: the checker compared only %0d of %0d cycles",
                     check_count, num_cycles + 1);
        end

        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== decode_checker.sv ====
`include "rv32i_cfg.svh"

module decode_checker (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [`XLEN-1:0]      instr_i,
    input  logic [`XLEN-1:0]      pc_i,
    input  rv32i_pkg::wb_port_t   wb_i,
    input  rv32i_pkg::fwd_bus_t   fwd_i,
    input  rv32i_pkg::fwd_sel_e   fwd_rs1_sel_i,
    input  rv32i_pkg::fwd_sel_e   fwd_rs2_sel_i,
    input  logic                  bubble_i,
    input  logic                  br_pred_i,
    input  rv32i_pkg::id_ex_t     id_ex_i,
    input  logic [`XLEN-1:0]      target_i,
    input  rv32i_pkg::pc_sel_e    pc_sel_i,
    input  logic                  flush_i,
    output int                    error_count_o,
    output int                    check_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`XLEN-1:0] shadow [`NUM_REGS];   // expected architectural state

    initial begin
        error_count_o = 0;
        check_count_o = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
    end

    // a write in the same cycle is already visible on the read
    function automatic logic [`XLEN-1:0] shadow_read(input logic [`REG_AW-1:0] addr);
        if (addr == '0) return '0;
        if (wb_i.load && (wb_i.rd == addr)) return wb_i.data;
        return shadow[addr];
    endfunction

    function automatic logic [`XLEN-1:0] forwarded_operand(
        input rv32i_pkg::fwd_sel_e sel,
        input logic [`XLEN-1:0]    own
    );
        case (sel)
            rv32i_pkg::ex_alu:  return fwd_i.ex_alu;
            rv32i_pkg::mem_alu: return fwd_i.mem_alu;
            rv32i_pkg::mem_ld:  return fwd_i.mem_ld;
            rv32i_pkg::wb_alu:  return fwd_i.wb_alu;
            rv32i_pkg::wb_ld:   return fwd_i.wb_ld;
            default:            return own;
        endcase
    endfunction

    task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            error_count_o++;
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cycle();
        rv32i_pkg::ctrl_word_t c;
        rv32i_pkg::pc_sel_e    sel;
        logic [6:0]            op;
        logic [2:0]            f3;
        logic [`XLEN-1:0]      sx;
        logic [`XLEN-1:0]      imm_i;
        logic [`XLEN-1:0]      imm_s;
        logic [`XLEN-1:0]      imm_b;
        logic [`XLEN-1:0]      imm_u;
        logic [`XLEN-1:0]      imm_j;
        logic [`XLEN-1:0]      rd1;
        logic [`XLEN-1:0]      rd2;
        logic [`XLEN-1:0]      op1;
        logic [`XLEN-1:0]      op2;
        logic [`XLEN-1:0]      rhs;
        logic [`XLEN-1:0]      tgt;
        logic                  eq;
        logic                  lt_s;
        logic                  lt_u;
        logic                  cmp;
        logic                  cf;
        logic                  taken;
        op = instr_i[6:0];
        f3 = instr_i[14:12];
        sx = instr_i[31] ? '1 : '0;
        imm_i = {sx[31:12], instr_i[31:20]};
        imm_s = {sx[31:12], instr_i[31:25], instr_i[11:7]};
        imm_b = {sx[31:13], instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        imm_u = {instr_i[31:12], 12'b0};
        imm_j = {sx[31:21], instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

        c = '0;
        c.opcode = rv32i_pkg::opcode_e'(op);
        c.alu_op = rv32i_pkg::alu_add;
        c.cmp_op = rv32i_pkg::branch_funct3_e'(f3);
        c.load_regfile = op inside {rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_jal,
            rv32i_pkg::op_jalr, rv32i_pkg::op_imm, rv32i_pkg::op_reg, rv32i_pkg::op_load};
        c.mem_read    = (op == rv32i_pkg::op_load);
        c.wb_from_mem = (op == rv32i_pkg::op_load);
        c.mem_write   = (op == rv32i_pkg::op_store);
        c.alu_src1_pc = op inside {rv32i_pkg::op_auipc, rv32i_pkg::op_jal, rv32i_pkg::op_jalr};
        c.alu_src2_imm = op inside {rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_jal,
            rv32i_pkg::op_jalr, rv32i_pkg::op_load, rv32i_pkg::op_store, rv32i_pkg::op_imm};
        c.cmp_imm = (op == rv32i_pkg::op_imm) && (f3[2:1] == 2'b01);   // slti, sltiu
        if (op == rv32i_pkg::op_load || op == rv32i_pkg::op_store) begin
            c.mem_byte_en = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        end
        if (op == rv32i_pkg::op_imm || op == rv32i_pkg::op_reg) begin
            c.alu_op = rv32i_pkg::alu_op_e'(f3);
            if (instr_i[30] && f3 == 3'b101) c.alu_op = rv32i_pkg::alu_sra;
            if (instr_i[30] && f3 == 3'b000 && op == rv32i_pkg::op_reg) begin
                c.alu_op = rv32i_pkg::alu_sub;
            end
        end
        if (bubble_i) begin
            c.opcode       = rv32i_pkg::op_bubble;
            c.load_regfile = 1'b0;
            c.mem_read     = 1'b0;
            c.mem_write    = 1'b0;
            c.mem_byte_en  = '0;
        end

        rd1 = shadow_read(instr_i[19:15]);
        rd2 = shadow_read(instr_i[24:20]);
        op1 = forwarded_operand(fwd_rs1_sel_i, rd1);
        op2 = forwarded_operand(fwd_rs2_sel_i, rd2);
        rhs = c.cmp_imm ? imm_i : op2;
        eq   = (op1 == rhs);
        lt_u = (op1 < rhs);
        lt_s = ({~op1[31], op1[30:0]} < {~rhs[31], rhs[30:0]});   // offset binary
        case (f3)
            3'b000:  cmp = eq;
            3'b001:  cmp = !eq;
            3'b100:  cmp = lt_s;
            3'b101:  cmp = !lt_s;
            3'b110:  cmp = lt_u;
            3'b111:  cmp = !lt_u;
            default: cmp = 1'b0;
        endcase

        cf    = c.opcode inside {rv32i_pkg::op_br, rv32i_pkg::op_jal, rv32i_pkg::op_jalr};
        taken = (c.opcode == rv32i_pkg::op_br) ? cmp : cf;
        sel   = rv32i_pkg::pc_plus4;
        tgt   = pc_i + 32'd4;
        if (c.opcode == rv32i_pkg::op_br && cmp) begin
            sel = rv32i_pkg::br_target;
            tgt = pc_i + imm_b;
        end else if (c.opcode == rv32i_pkg::op_jal) begin
            sel = rv32i_pkg::br_target;
            tgt = pc_i + imm_j;
        end else if (c.opcode == rv32i_pkg::op_jalr) begin
            sel = rv32i_pkg::jalr_target;
            tgt = (op1 + imm_i) & ~32'h1;
        end

        check_field("rs1 field", id_ex_i.rs1, instr_i[19:15]);
        check_field("rs2 field", id_ex_i.rs2, instr_i[24:20]);
        check_field("rd field", id_ex_i.rd, instr_i[11:7]);
        check_field("i_imm", id_ex_i.i_imm, imm_i);
        check_field("s_imm", id_ex_i.s_imm, imm_s);
        check_field("b_imm", id_ex_i.b_imm, imm_b);
        check_field("u_imm", id_ex_i.u_imm, imm_u);
        check_field("j_imm", id_ex_i.j_imm, imm_j);
        check_field("rs1 read", id_ex_i.rs1_data, rd1);
        check_field("rs2 read", id_ex_i.rs2_data, rd2);
        check_field("control word", id_ex_i.ctrl, c);
        check_field("pc", id_ex_i.pc, pc_i);
        check_field("instr", id_ex_i.instr, instr_i);
        check_field("br_pred", id_ex_i.br_pred, br_pred_i);
        check_field("br_en", id_ex_i.br_en, cmp);
        check_field("target", target_i, tgt);
        check_field("pc_sel", pc_sel_i, sel);
        check_field("flush", flush_i, cf && (taken != br_pred_i));
        check_count_o++;
    endtask

    // inputs settle on the rising edge, compare half a cycle later
    always @(negedge clk) begin
        if (!rst_i) begin
            check_cycle();
        end
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                shadow[i] = '0;
            end
        end else if (wb_i.load && (wb_i.rd != '0)) begin
            shadow[wb_i.rd] = wb_i.data;   // lands on the coming edge
        end
    end

endmodule

// ==== decode_stage.sv ====
`include "rv32i_cfg.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [`XLEN-1:0]      instr_i,
    input  logic [`XLEN-1:0]      pc_i,
    input  rv32i_pkg::wb_port_t   wb_i,
    input  rv32i_pkg::fwd_bus_t   fwd_i,
    input  rv32i_pkg::fwd_sel_e   fwd_rs1_sel_i,
    input  rv32i_pkg::fwd_sel_e   fwd_rs2_sel_i,
    input  logic                  bubble_i,
    input  logic                  br_pred_i,
    output rv32i_pkg::id_ex_t     id_ex_o,
    output logic [`XLEN-1:0]      target_o,
    output rv32i_pkg::pc_sel_e    pc_sel_o,
    output logic                  flush_o
);

    rv32i_pkg::opcode_e    opcode;
    rv32i_pkg::ctrl_word_t ctrl;
    rv32i_pkg::ctrl_word_t ctrl_id;   // after bubble insertion
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`REG_AW-1:0]    rs1;
    logic [`REG_AW-1:0]    rs2;
    logic [`REG_AW-1:0]    rd;
    logic [`XLEN-1:0]      i_imm;
    logic [`XLEN-1:0]      s_imm;
    logic [`XLEN-1:0]      b_imm;
    logic [`XLEN-1:0]      u_imm;
    logic [`XLEN-1:0]      j_imm;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic [`XLEN-1:0]      br_rs1;
    logic [`XLEN-1:0]      br_rs2;
    logic                  br_en;

    assign opcode = rv32i_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];

    // standard RV32I immediate layouts, all sign extended from bit 31
    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'h000};
    assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    control_rom u_control_rom (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (ctrl)
    );

    always_comb begin
        ctrl_id = ctrl;
        if (bubble_i) begin
            ctrl_id.opcode       = rv32i_pkg::op_bubble;   // keeps branch_unit quiet
            ctrl_id.load_regfile = 1'b0;
            ctrl_id.mem_read     = 1'b0;
            ctrl_id.mem_write    = 1'b0;
            ctrl_id.mem_byte_en  = '0;
        end
    end

    regfile u_regfile (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_i       (wb_i),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    function automatic logic [`XLEN-1:0] fwd_pick(
        input rv32i_pkg::fwd_sel_e sel,
        input logic [`XLEN-1:0]    own,
        input rv32i_pkg::fwd_bus_t bus
    );
        case (sel)
            rv32i_pkg::id:      return own;
            rv32i_pkg::ex_alu:  return bus.ex_alu;
            rv32i_pkg::mem_alu: return bus.mem_alu;
            rv32i_pkg::mem_ld:  return bus.mem_ld;
            rv32i_pkg::wb_alu:  return bus.wb_alu;
            rv32i_pkg::wb_ld:   return bus.wb_ld;
            default:            return own;   // spare select codes
        endcase
    endfunction

    assign br_rs1 = fwd_pick(fwd_rs1_sel_i, rs1_data, fwd_i);
    assign br_rs2 = fwd_pick(fwd_rs2_sel_i, rs2_data, fwd_i);

    branch_unit u_branch_unit (
        .ctrl_i    (ctrl_id),
        .rs1_i     (br_rs1),
        .rs2_i     (br_rs2),
        .pc_i      (pc_i),
        .i_imm_i   (i_imm),
        .b_imm_i   (b_imm),
        .j_imm_i   (j_imm),
        .br_pred_i (br_pred_i),
        .br_en_o   (br_en),
        .target_o  (target_o),
        .pc_sel_o  (pc_sel_o),
        .flush_o   (flush_o)
    );

    always_comb begin
        id_ex_o.ctrl     = ctrl_id;
        id_ex_o.pc       = pc_i;
        id_ex_o.instr    = instr_i;
        id_ex_o.rs1_data = rs1_data;   // EX does its own forwarding
        id_ex_o.rs2_data = rs2_data;
        id_ex_o.i_imm    = i_imm;
        id_ex_o.s_imm    = s_imm;
        id_ex_o.b_imm    = b_imm;
        id_ex_o.u_imm    = u_imm;
        id_ex_o.j_imm    = j_imm;
        id_ex_o.rs1      = rs1;
        id_ex_o.rs2      = rs2;
        id_ex_o.rd       = rd;
        id_ex_o.br_en    = br_en;
        id_ex_o.br_pred  = br_pred_i;
    end

endmodule

// ==== branch_unit.sv ====
`include "rv32i_cfg.svh"

module branch_unit (
    input  rv32i_pkg::ctrl_word_t ctrl_i,
    input  logic [`XLEN-1:0]      rs1_i,
    input  logic [`XLEN-1:0]      rs2_i,
    input  logic [`XLEN-1:0]      pc_i,
    input  logic [`XLEN-1:0]      i_imm_i,
    input  logic [`XLEN-1:0]      b_imm_i,
    input  logic [`XLEN-1:0]      j_imm_i,
    input  logic                  br_pred_i,
    output logic                  br_en_o,
    output logic [`XLEN-1:0]      target_o,
    output rv32i_pkg::pc_sel_e    pc_sel_o,
    output logic                  flush_o
);

    logic [`XLEN-1:0] cmp_rhs;
    logic [`XLEN-1:0] jalr_sum;
    logic             taken;
    logic             is_cf;

    assign cmp_rhs  = ctrl_i.cmp_imm ? i_imm_i : rs2_i;
    assign jalr_sum = rs1_i + i_imm_i;

    always_comb begin
        case (ctrl_i.cmp_op)
            rv32i_pkg::beq:  br_en_o = (rs1_i == cmp_rhs);
            rv32i_pkg::bne:  br_en_o = (rs1_i != cmp_rhs);
            rv32i_pkg::blt:  br_en_o = ($signed(rs1_i) < $signed(cmp_rhs));
            rv32i_pkg::bge:  br_en_o = ($signed(rs1_i) >= $signed(cmp_rhs));
            rv32i_pkg::bltu: br_en_o = (rs1_i < cmp_rhs);
            rv32i_pkg::bgeu: br_en_o = (rs1_i >= cmp_rhs);
            default:         br_en_o = 1'b0;
        endcase
    end

    always_comb begin
        target_o = pc_i + `XLEN'(4);
        pc_sel_o = rv32i_pkg::pc_plus4;
        taken    = 1'b0;
        is_cf    = 1'b0;
        case (ctrl_i.opcode)
            rv32i_pkg::op_br: begin
                is_cf = 1'b1;
                taken = br_en_o;
                if (br_en_o) begin
                    target_o = pc_i + b_imm_i;
                    pc_sel_o = rv32i_pkg::br_target;
                end
            end
            rv32i_pkg::op_jal: begin
                is_cf    = 1'b1;
                taken    = 1'b1;
                target_o = pc_i + j_imm_i;
                pc_sel_o = rv32i_pkg::br_target;
            end
            rv32i_pkg::op_jalr: begin
                is_cf    = 1'b1;
                taken    = 1'b1;
                target_o = {jalr_sum[`XLEN-1:1], 1'b0};   // lsb cleared per spec
                pc_sel_o = rv32i_pkg::jalr_target;
            end
            default: ;
        endcase
    end

    // fetch guessed wrong, squash the IF/ID slot
    assign flush_o = is_cf && (taken != br_pred_i);

endmodule

// ==== control_rom.sv ====
module control_rom (
    input  rv32i_pkg::opcode_e    opcode_i,
    input  logic [2:0]            funct3_i,
    input  logic [6:0]            funct7_i,
    output rv32i_pkg::ctrl_word_t ctrl_o
);

    rv32i_pkg::alu_op_e alu_from_funct;
    logic [3:0]         byte_en;

    // arithmetic op for the imm and reg formats
    always_comb begin
        alu_from_funct = rv32i_pkg::alu_op_e'(funct3_i);
        if ((funct3_i == 3'b101) && funct7_i[5]) begin
            alu_from_funct = rv32i_pkg::alu_sra;   // srai / sra
        end
    end

    always_comb begin
        case (funct3_i[1:0])
            2'b00:   byte_en = 4'b0001;   // byte
            2'b01:   byte_en = 4'b0011;   // half
            default: byte_en = 4'b1111;   // word
        endcase
    end

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.opcode = opcode_i;
        ctrl_o.alu_op = rv32i_pkg::alu_add;
        ctrl_o.cmp_op = rv32i_pkg::branch_funct3_e'(funct3_i);

        case (opcode_i)
            rv32i_pkg::op_lui: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_src2_imm = 1'b1;
            end
            rv32i_pkg::op_auipc, rv32i_pkg::op_jal, rv32i_pkg::op_jalr: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_src1_pc  = 1'b1;   // link value or pc + u_imm
                ctrl_o.alu_src2_imm = 1'b1;
            end
            rv32i_pkg::op_load: begin
                ctrl_o.mem_read     = 1'b1;
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.wb_from_mem  = 1'b1;
                ctrl_o.alu_src2_imm = 1'b1;
                ctrl_o.mem_byte_en  = byte_en;
            end
            rv32i_pkg::op_store: begin
                ctrl_o.mem_write    = 1'b1;
                ctrl_o.alu_src2_imm = 1'b1;
                ctrl_o.mem_byte_en  = byte_en;
            end
            rv32i_pkg::op_imm: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_src2_imm = 1'b1;
                ctrl_o.alu_op       = alu_from_funct;
                ctrl_o.cmp_imm      = (funct3_i == 3'b010) || (funct3_i == 3'b011);
            end
            rv32i_pkg::op_reg: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_op       = alu_from_funct;
                if ((funct3_i == 3'b000) && funct7_i[5]) begin
                    ctrl_o.alu_op = rv32i_pkg::alu_sub;
                end
            end
            default: ;   // br and unknown opcodes keep the default word
        endcase
    end

endmodule

// ==== regfile.sv ====
`include "rv32i_cfg.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst_i,
    input  rv32i_pkg::wb_port_t  wr_i,
    input  logic [`REG_AW-1:0]   rs1_addr_i,
    input  logic [`REG_AW-1:0]   rs2_addr_i,
    output logic [`XLEN-1:0]     rs1_data_o,
    output logic [`XLEN-1:0]     rs2_data_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS-1:1];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.load && (wr_i.rd != '0)) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    // x0 reads zero, a same-cycle write wins over the stored value
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        logic [`XLEN-1:0] val;
        if (addr == '0) val = '0;
        else if (wr_i.load && (wr_i.rd == addr)) val = wr_i.data;
        else val = regs[addr];
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

// ==== rv32i_pkg.sv ====
`include "rv32i_cfg.svh"

package rv32i_pkg;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_br     = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_bubble = 7'b1111111   // not a real opcode, marks a squashed slot
    } opcode_e;

    // encodings match funct3 of the branch instructions
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    // lines up with funct3 for the non-shift ops
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    typedef enum logic [2:0] {
        id      = 3'd0,   // own regfile read
        ex_alu  = 3'd1,
        mem_alu = 3'd2,
        mem_ld  = 3'd3,
        wb_alu  = 3'd4,
        wb_ld   = 3'd5
    } fwd_sel_e;

    typedef enum logic [1:0] {
        pc_plus4    = 2'd0,
        br_target   = 2'd1,
        jalr_target = 2'd2
    } pc_sel_e;

    typedef struct packed {
        opcode_e        opcode;
        alu_op_e        alu_op;
        logic           alu_src1_pc;    // pc instead of rs1
        logic           alu_src2_imm;   // immediate instead of rs2
        branch_funct3_e cmp_op;
        logic           cmp_imm;        // compare against i_imm
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        logic [3:0]     mem_byte_en;
        logic           wb_from_mem;
    } ctrl_word_t;

    typedef struct packed {
        logic [`XLEN-1:0] ex_alu;
        logic [`XLEN-1:0] mem_alu;
        logic [`XLEN-1:0] mem_ld;
        logic [`XLEN-1:0] wb_alu;
        logic [`XLEN-1:0] wb_ld;
    } fwd_bus_t;

    typedef struct packed {
        logic              load;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]  data;
    } wb_port_t;

    typedef struct packed {
        ctrl_word_t         ctrl;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instr;
        logic [`XLEN-1:0]   rs1_data;   // regfile read, not forwarded
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   i_imm;
        logic [`XLEN-1:0]   s_imm;
        logic [`XLEN-1:0]   b_imm;
        logic [`XLEN-1:0]   u_imm;
        logic [`XLEN-1:0]   j_imm;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
        logic               br_en;
        logic               br_pred;
    } id_ex_t;

endpackage

// ==== rv32i_cfg.svh ====
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// datapath width
`define XLEN 32

// architectural register file
`define NUM_REGS 32
`define REG_AW 5

`endif
